/* cpu_core.f */
+incdir+include
logic/cpu_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/alu_unit.sv
logic/load_store_unit.sv
logic/commit_stage.sv
logic/cpu_core.sv
bench/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the cpu_core testbench with verilator, run it, and search the log for the fail message

cd "$(dirname "$0")" || exit 1

log_file=sim.log
build_dir=obj_dir

verilator --binary --timing --timescale 1ns/1ps -f cpu_core.f --top-module cpu_tb \
	-Mdir "$build_dir" -o cpu_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/cpu_tb_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$log_file"; then
	echo "simulation failed, see $log_file"
	exit 1
fi
echo "simulation passed"
exit 0

/* bench/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_tb;

	localparam int reset_cycles = 16;
	localparam int directed_max = 300;
	localparam int random_steps = 2000;
	localparam int timeout_cycles = reset_cycles + directed_max + random_steps + 284;

	logic clk = 1'b0;
	logic reset = 1'b1;
	cpu_pkg::instr_u instr = '0;
	logic [`CPU_XLEN-1:0] pc;
	cpu_pkg::wb_t wb;

	cpu_pkg::instr_u prog [256];  // indexed by pc low bits
	int asm_addr;
	logic [31:0] halt_addr;
	logic random_phase = 1'b0;
	string test_name = "directed";
	string step_name;
	logic [31:0] lfsr_state = 32'h707f5e2b;
	int rand_steps = 0;
	int cycle_count = 0;
	int wb_errors = 0;
	int pc_errors = 0;

	// reference machine state
	logic [31:0] m_regs [32];
	logic [31:0] m_mem [64];
	cpu_pkg::flags_t m_flags;
	logic [31:0] m_pc;
	cpu_pkg::wb_t exp_wb;

	cpu_pkg::opcode_e legal_ops [23] = '{cpu_pkg::op_add, cpu_pkg::op_comp, cpu_pkg::op_and,
		cpu_pkg::op_xor, cpu_pkg::op_shll, cpu_pkg::op_shrl, cpu_pkg::op_shllv, cpu_pkg::op_shrlv,
		cpu_pkg::op_shra, cpu_pkg::op_shrav, cpu_pkg::op_addi, cpu_pkg::op_compi, cpu_pkg::op_lw,
		cpu_pkg::op_sw, cpu_pkg::op_bz, cpu_pkg::op_bnz, cpu_pkg::op_bcy, cpu_pkg::op_bncy,
		cpu_pkg::op_bs, cpu_pkg::op_bns, cpu_pkg::op_bv, cpu_pkg::op_bnv, cpu_pkg::op_b};

	cpu_core i_dut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.pc(pc),
		.wb(wb)
	);

	always #50 clk = ~clk;

	////////////////////
	// stimulus helpers

	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'hd0000001;  // galois taps
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic cpu_pkg::instr_u enc_r(input cpu_pkg::opcode_e op, input logic [31:0] rs,
		input logic [31:0] rt, input logic [31:0] imm);
		cpu_pkg::instr_u w;
		w.r.opcode = op;
		w.r.rs = rs[4:0];
		w.r.rt = rt[4:0];
		w.r.imm = imm[15:0];
		return w;
	endfunction

	function automatic cpu_pkg::instr_u enc_j(input cpu_pkg::opcode_e op, input logic [31:0] t);
		cpu_pkg::instr_u w;
		w.j.opcode = op;
		w.j.target = t[25:0];
		return w;
	endfunction

	function automatic cpu_pkg::instr_u random_instr();
		cpu_pkg::opcode_e op;
		logic [31:0] rs;
		logic [31:0] rt;
		op = legal_ops[rand_bits(5) % 23];
		if (op inside {[cpu_pkg::op_bz:cpu_pkg::op_b]})
			return enc_j(op, rand_bits(8));  // target inside the program store
		rs = rand_bits(5);
		rt = rand_bits(5);
		return enc_r(op, rs, rt, rand_bits(16));
	endfunction

	task automatic emit(input cpu_pkg::instr_u w);
		prog[asm_addr] = w;
		asm_addr++;
	endtask

	// taken one skips the r9 filler, not taken one runs it
	task automatic branch_pair(input cpu_pkg::opcode_e taken, input cpu_pkg::opcode_e not_taken);
		emit(enc_j(taken, asm_addr + 2));
		emit(enc_r(cpu_pkg::op_addi, 9, 0, 1));
		emit(enc_j(not_taken, asm_addr + 2));
		emit(enc_r(cpu_pkg::op_addi, 9, 0, 1));
	endtask

	task automatic load_directed();
		int top;
		for (int i = 0; i < 256; i++)
			prog[i] = '0;
		asm_addr = 0;
		emit(enc_r(cpu_pkg::op_addi, 1, 0, 32'h7fff));
		emit(enc_r(cpu_pkg::op_addi, 2, 0, -1));  // sign extension
		emit(enc_r(cpu_pkg::op_addi, 3, 0, -32768));
		emit(enc_r(cpu_pkg::op_addi, 4, 0, 5));
		emit(enc_r(cpu_pkg::op_xor, 5, 5, 0));
		branch_pair(cpu_pkg::op_bz, cpu_pkg::op_bnz);
		emit(enc_r(cpu_pkg::op_and, 1, 2, 0));
		branch_pair(cpu_pkg::op_bnz, cpu_pkg::op_bz);
		emit(enc_r(cpu_pkg::op_add, 4, 2, 0));  // carry set
		branch_pair(cpu_pkg::op_bcy, cpu_pkg::op_bncy);
		emit(enc_r(cpu_pkg::op_add, 4, 4, 0));
		branch_pair(cpu_pkg::op_bncy, cpu_pkg::op_bcy);
		emit(enc_r(cpu_pkg::op_comp, 6, 1, 0));
		branch_pair(cpu_pkg::op_bs, cpu_pkg::op_bns);
		emit(enc_r(cpu_pkg::op_addi, 7, 0, -1));
		emit(enc_r(cpu_pkg::op_shrl, 7, 0, 1));
		emit(enc_r(cpu_pkg::op_add, 7, 4, 0));  // max positive plus 8 overflows
		branch_pair(cpu_pkg::op_bv, cpu_pkg::op_bnv);
		emit(enc_r(cpu_pkg::op_add, 7, 2, 0));
		branch_pair(cpu_pkg::op_bnv, cpu_pkg::op_bv);
		// variable shifts by 31, 40 and 0
		emit(enc_r(cpu_pkg::op_addi, 10, 0, 31));
		emit(enc_r(cpu_pkg::op_addi, 11, 0, 40));
		emit(enc_r(cpu_pkg::op_shllv, 1, 10, 0));
		emit(enc_r(cpu_pkg::op_shrav, 3, 10, 0));
		emit(enc_r(cpu_pkg::op_shrlv, 2, 11, 0));
		emit(enc_r(cpu_pkg::op_shllv, 4, 12, 0));
		emit(enc_r(cpu_pkg::op_shrav, 6, 11, 0));  // all ones, s stays clear
		branch_pair(cpu_pkg::op_bns, cpu_pkg::op_bs);
		emit(enc_r(cpu_pkg::op_shll, 1, 0, 31));
		emit(enc_r(cpu_pkg::op_shrl, 7, 0, 40));
		emit(enc_r(cpu_pkg::op_shra, 6, 0, 31));
		emit(enc_r(cpu_pkg::op_shrl, 3, 0, 0));
		emit(enc_r(cpu_pkg::op_shll, 4, 0, -1));  // huge amount
		emit(enc_r(cpu_pkg::op_compi, 13, 0, -5));
		emit(enc_r(cpu_pkg::op_addi, 13, 0, -10));
		////////////////////
		// memory, flags left by the last addi
		emit(enc_r(cpu_pkg::op_addi, 20, 0, 8));
		emit(enc_r(cpu_pkg::op_addi, 21, 0, 32'h1234));
		emit(enc_r(cpu_pkg::op_addi, 22, 0, -2));
		emit(enc_r(cpu_pkg::op_sw, 20, 21, 0));
		emit(enc_r(cpu_pkg::op_sw, 20, 22, 5));
		emit(enc_r(cpu_pkg::op_sw, 20, 3, -3));
		emit(enc_r(cpu_pkg::op_sw, 20, 13, 60));  // wraps to word 4
		emit(enc_r(cpu_pkg::op_lw, 20, 24, 0));
		emit(enc_r(cpu_pkg::op_lw, 20, 25, 5));
		emit(enc_r(cpu_pkg::op_lw, 20, 26, -3));
		emit(enc_r(cpu_pkg::op_lw, 20, 27, -4));
		emit(enc_j(cpu_pkg::op_b, asm_addr + 2));
		emit(enc_r(cpu_pkg::op_addi, 9, 0, 1));
		branch_pair(cpu_pkg::op_bs, cpu_pkg::op_bz);
		// three passes, forward jump out, backward branch in
		emit(enc_r(cpu_pkg::op_addi, 28, 0, 3));
		top = asm_addr;
		emit(enc_r(cpu_pkg::op_addi, 28, 0, -1));
		emit(enc_j(cpu_pkg::op_bnz, top + 3));
		emit(enc_j(cpu_pkg::op_b, top + 4));
		emit(enc_j(cpu_pkg::op_bns, top));
		halt_addr = asm_addr;
		emit(enc_j(cpu_pkg::op_b, asm_addr));
	endtask

	task automatic fetch_on_fall();
		@(negedge clk);
		if (!reset && !random_phase && pc == halt_addr)
		begin
			for (int i = 0; i < 256; i++)
				prog[i] = random_instr();
			random_phase = 1'b1;
			test_name = "random";
		end
		instr = prog[pc[7:0]];
	endtask

	////////////////////
	// reference model

	task automatic model_reset();
		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		for (int i = 0; i < 64; i++)
			m_mem[i] = '0;
		m_flags = '0;
		m_pc = '0;
	endtask

	function automatic cpu_pkg::wb_t ref_step(input cpu_pkg::instr_u ins);
		cpu_pkg::wb_t res;
		cpu_pkg::flags_t f;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] sx;
		logic [5:0] ea;
		logic take;
		a = m_regs[ins.r.rs];
		b = m_regs[ins.r.rt];
		sx = {{16{ins.r.imm[15]}}, ins.r.imm};
		if (ins.r.opcode inside {cpu_pkg::op_addi, cpu_pkg::op_compi, cpu_pkg::op_shll,
			cpu_pkg::op_shrl, cpu_pkg::op_shra})
			b = sx;
		ea = 6'(a + sx);
		res = '0;
		f = '0;
		r = '0;
		take = 1'b0;
		case (ins.r.opcode)
			cpu_pkg::op_add, cpu_pkg::op_addi:
			begin
				r = a + b;
				f.c = a[31] ^ b[31] ^ r[31];
				f.v = (a[31] & b[31] & !r[31]) | (!a[31] & !b[31] & r[31]);
			end
			cpu_pkg::op_comp, cpu_pkg::op_compi: r = ~b + 32'd1;
			cpu_pkg::op_and: r = a & b;
			cpu_pkg::op_xor: r = a ^ b;
			cpu_pkg::op_shll, cpu_pkg::op_shllv: r = (b > 31) ? '0 : a << b[4:0];
			cpu_pkg::op_shrl, cpu_pkg::op_shrlv: r = (b > 31) ? '0 : a >> b[4:0];
			cpu_pkg::op_shra, cpu_pkg::op_shrav:
			begin
				r = $signed(a) >>> b[4:0];
				if (b > 31)
					r = {32{a[31]}};  // only sign bits left
			end
			cpu_pkg::op_lw:
			begin
				res = {1'b1, ins.r.rt, m_mem[ea]};
				m_regs[ins.r.rt] = m_mem[ea];
			end
			cpu_pkg::op_sw: m_mem[ea] = b;
			cpu_pkg::op_bz: take = m_flags.z;
			cpu_pkg::op_bnz: take = !m_flags.z;
			cpu_pkg::op_bcy: take = m_flags.c;
			cpu_pkg::op_bncy: take = !m_flags.c;
			cpu_pkg::op_bs: take = m_flags.s;
			cpu_pkg::op_bns: take = !m_flags.s;
			cpu_pkg::op_bv: take = m_flags.v;
			cpu_pkg::op_bnv: take = !m_flags.v;
			cpu_pkg::op_b: take = 1'b1;
			default: take = 1'b0;
		endcase
		if (ins.r.opcode inside {[cpu_pkg::op_add:cpu_pkg::op_shrav], cpu_pkg::op_addi,
			cpu_pkg::op_compi})
		begin
			if (!(ins.r.opcode inside {[cpu_pkg::op_shll:cpu_pkg::op_shrav]}))
			begin
				f.z = (r == 0);
				f.s = r[31];
			end
			m_flags = f;
			m_regs[ins.r.rs] = r;
			res = {1'b1, ins.r.rs, r};
		end
		m_pc = take ? {m_pc[31:26], ins.j.target} : m_pc + 32'd1;
		return res;
	endfunction

	////////////////////
	// checks

	task automatic check_wb(input string name, input cpu_pkg::wb_t expected,
		input cpu_pkg::wb_t actual);
		if (expected.valid !== actual.valid || (expected.valid
			&& (expected.dest !== actual.dest || expected.data !== actual.data)))
		begin
			wb_errors++;
			$display("FAIL %s wb expected valid %b dest %0d data %h, actual valid %b dest %0d data %h",
				name, expected.valid, expected.dest, expected.data,
				actual.valid, actual.dest, actual.data);
		end
	endtask

	task automatic check_pc(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			pc_errors++;
			$display("FAIL %s pc expected %0d actual %0d", name, expected, actual);
		end
	endtask

	always @(negedge clk)
	begin
		#25;  // low phase, instr and wb settled
		if (reset)
		begin
			model_reset();
			check_wb("reset", '0, wb);  // no write while in reset
		end
		else
		begin
			step_name = $sformatf("%s pc %0d", test_name, m_pc);
			check_pc(step_name, m_pc, pc);  // pc left by the previous edge
			exp_wb = ref_step(prog[m_pc[7:0]]);
			check_wb(step_name, exp_wb, wb);
			if (random_phase)
				rand_steps++;
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout, the program did not finish within %0d cycles", timeout_cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		load_directed();
		repeat (reset_cycles)
			fetch_on_fall();
		reset = 1'b0;
		while (rand_steps < random_steps)
			fetch_on_fall();
		#30;  // last pc check
		$display("error counts: wb %0d, pc %0d", wb_errors, pc_errors);
		if (wb_errors + pc_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* logic/cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_core
(
	input logic clk,
	input logic reset,
	input cpu_pkg::instr_u instr,
	output logic [`CPU_XLEN-1:0] pc,
	output cpu_pkg::wb_t wb
);

	cpu_pkg::ctrl_t ctrl;
	cpu_pkg::flags_t flags;
	logic [`CPU_XLEN-1:0] imm;
	logic [`CPU_XLEN-1:0] rs_data;
	logic [`CPU_XLEN-1:0] rt_data;
	logic [`CPU_XLEN-1:0] alu_result;
	logic [`CPU_XLEN-1:0] load_data;

	instr_decoder i_decoder (
		.instr(instr),
		.ctrl(ctrl),
		.imm(imm)
	);

	// write port fed back from commit
	reg_file i_reg_file (
		.clk(clk),
		.reset(reset),
		.rs(instr.r.rs),
		.rt(instr.r.rt),
		.wb(wb),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	////////////////////
	// execute, both units in parallel
	alu_unit i_alu (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.imm(imm),
		.alu_result(alu_result),
		.flags(flags)
	);

	load_store_unit i_lsu (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.imm(imm),
		.load_data(load_data)
	);

	commit_stage i_commit (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.instr(instr),
		.flags(flags),
		.alu_result(alu_result),
		.load_data(load_data),
		.pc(pc),
		.wb(wb)
	);

endmodule

/* logic/commit_stage.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module commit_stage
(
	input logic clk,
	input logic reset,
	input cpu_pkg::ctrl_t ctrl,
	input cpu_pkg::instr_u instr,
	input cpu_pkg::flags_t flags,
	input logic [`CPU_XLEN-1:0] alu_result,
	input logic [`CPU_XLEN-1:0] load_data,
	output logic [`CPU_XLEN-1:0] pc,
	output cpu_pkg::wb_t wb
);

	logic cond_hold;
	logic take;
	logic [`CPU_XLEN-1:0] target;
	logic [`CPU_XLEN-1:0] pc_next;

	////////////////////
	// branch decision
	always_comb
	begin
		case (ctrl.cond)
			cpu_pkg::cond_z: cond_hold = flags.z;
			cpu_pkg::cond_nz: cond_hold = !flags.z;
			cpu_pkg::cond_cy: cond_hold = flags.c;
			cpu_pkg::cond_ncy: cond_hold = !flags.c;
			cpu_pkg::cond_s: cond_hold = flags.s;
			cpu_pkg::cond_ns: cond_hold = !flags.s;
			cpu_pkg::cond_v: cond_hold = flags.v;
			cpu_pkg::cond_nv: cond_hold = !flags.v;
			default: cond_hold = 1'b0;
		endcase
	end

	assign take = ctrl.jump || (ctrl.branch && cond_hold);

	// pc keeps its top bits, target fills the rest
	assign target = {pc[`CPU_XLEN-1 -: `CPU_PC_HI_W], instr.j.target};
	assign pc_next = take ? target : pc + `CPU_XLEN'(1);

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;
		else
			pc <= pc_next;
	end

	////////////////////
	// writeback select
	always_comb
	begin
		wb.valid = (ctrl.alu_wr || ctrl.load) && !reset;
		wb.dest = ctrl.load ? instr.r.rt : instr.r.rs;  // loads land in rt
		wb.data = ctrl.load ? load_data : alu_result;
	end

endmodule

/* logic/load_store_unit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module load_store_unit
(
	input logic clk,
	input logic reset,
	input cpu_pkg::ctrl_t ctrl,
	input logic [`CPU_XLEN-1:0] rs_data,
	input logic [`CPU_XLEN-1:0] rt_data,
	input logic [`CPU_XLEN-1:0] imm,
	output logic [`CPU_XLEN-1:0] load_data
);

	logic [`CPU_XLEN-1:0] mem [`CPU_DMEM_DEPTH];
	logic [`CPU_XLEN-1:0] eff_addr;
	logic [`CPU_DMEM_AW-1:0] addr;

	// own adder, upper bits wrap away
	assign eff_addr = rs_data + imm;
	assign addr = eff_addr[`CPU_DMEM_AW-1:0];

	assign load_data = mem[addr];  // async read

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `CPU_DMEM_DEPTH; i++)
				mem[i] <= '0;
		end
		else if (ctrl.store)
			mem[addr] <= rt_data;
	end

endmodule

/* logic/alu_unit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu_unit
(
	input logic clk,
	input logic reset,
	input cpu_pkg::ctrl_t ctrl,
	input logic [`CPU_XLEN-1:0] rs_data,
	input logic [`CPU_XLEN-1:0] rt_data,
	input logic [`CPU_XLEN-1:0] imm,
	output logic [`CPU_XLEN-1:0] alu_result,
	output cpu_pkg::flags_t flags
);

	logic [`CPU_XLEN-1:0] b_op;
	cpu_pkg::flags_t flags_next;

	assign b_op = ctrl.use_imm ? imm : rt_data;

	////////////////////
	// result and next flags
	always_comb
	begin
		alu_result = '0;
		flags_next = '0;
		case (ctrl.alu_op)
			cpu_pkg::alu_add:
			begin
				alu_result = rs_data + b_op;
				flags_next.c = rs_data[`CPU_XLEN-1] ^ b_op[`CPU_XLEN-1]
					^ alu_result[`CPU_XLEN-1];
				// same operand signs, result sign flipped
				flags_next.v = (rs_data[`CPU_XLEN-1] == b_op[`CPU_XLEN-1])
					&& (alu_result[`CPU_XLEN-1] != rs_data[`CPU_XLEN-1]);
			end
			cpu_pkg::alu_neg: alu_result = -b_op;  // a not used
			cpu_pkg::alu_and: alu_result = rs_data & b_op;
			cpu_pkg::alu_xor: alu_result = rs_data ^ b_op;
			// amounts of 32 and up shift everything out
			cpu_pkg::alu_shl: alu_result = rs_data << b_op;
			cpu_pkg::alu_shr: alu_result = rs_data >> b_op;
			cpu_pkg::alu_sra: alu_result = $signed(rs_data) >>> b_op;
			default: alu_result = '0;
		endcase

		// z and s for the arithmetic and logic group only, shifts keep all flags low
		if (ctrl.alu_op inside {cpu_pkg::alu_add, cpu_pkg::alu_neg,
			cpu_pkg::alu_and, cpu_pkg::alu_xor})
		begin
			flags_next.z = (alu_result == '0);
			flags_next.s = alu_result[`CPU_XLEN-1];
		end
	end

	////////////////////
	// flag register
	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else if (ctrl.alu_wr)
			flags <= flags_next;  // loads, stores, branches hold
	end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module reg_file
(
	input logic clk,
	input logic reset,
	input logic [`CPU_REG_AW-1:0] rs,
	input logic [`CPU_REG_AW-1:0] rt,
	input cpu_pkg::wb_t wb,
	output logic [`CPU_XLEN-1:0] rs_data,
	output logic [`CPU_XLEN-1:0] rt_data
);

	logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

	// two read ports, no bypass
	assign rs_data = regs[rs];
	assign rt_data = regs[rt];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wb.valid)
			regs[wb.dest] <= wb.data;  // r0 is writable
	end

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module instr_decoder
(
	input cpu_pkg::instr_u instr,
	output cpu_pkg::ctrl_t ctrl,
	output logic [`CPU_XLEN-1:0] imm
);

	cpu_pkg::opcode_e opcode;

	assign opcode = instr.r.opcode;

	// sign extend from the register/immediate view
	assign imm = {{(`CPU_XLEN-`CPU_IMM_W){instr.r.imm[`CPU_IMM_W-1]}}, instr.r.imm};

	always_comb
	begin
		ctrl = '0;

		////////////////////
		// alu operation
		case (opcode)
			cpu_pkg::op_comp, cpu_pkg::op_compi: ctrl.alu_op = cpu_pkg::alu_neg;
			cpu_pkg::op_and: ctrl.alu_op = cpu_pkg::alu_and;
			cpu_pkg::op_xor: ctrl.alu_op = cpu_pkg::alu_xor;
			cpu_pkg::op_shll, cpu_pkg::op_shllv: ctrl.alu_op = cpu_pkg::alu_shl;
			cpu_pkg::op_shrl, cpu_pkg::op_shrlv: ctrl.alu_op = cpu_pkg::alu_shr;
			cpu_pkg::op_shra, cpu_pkg::op_shrav: ctrl.alu_op = cpu_pkg::alu_sra;
			default: ctrl.alu_op = cpu_pkg::alu_add;  // add, addi and the rest
		endcase

		// immediate forms take b from imm
		case (opcode)
			cpu_pkg::op_addi,
			cpu_pkg::op_compi,
			cpu_pkg::op_shll,
			cpu_pkg::op_shrl,
			cpu_pkg::op_shra: ctrl.use_imm = 1'b1;
			default: ctrl.use_imm = 1'b0;
		endcase

		////////////////////
		// instruction class
		case (opcode)
			cpu_pkg::op_add,
			cpu_pkg::op_comp,
			cpu_pkg::op_and,
			cpu_pkg::op_xor,
			cpu_pkg::op_shll,
			cpu_pkg::op_shrl,
			cpu_pkg::op_shllv,
			cpu_pkg::op_shrlv,
			cpu_pkg::op_shra,
			cpu_pkg::op_shrav,
			cpu_pkg::op_addi,
			cpu_pkg::op_compi: ctrl.alu_wr = 1'b1;
			cpu_pkg::op_lw: ctrl.load = 1'b1;
			cpu_pkg::op_sw: ctrl.store = 1'b1;
			cpu_pkg::op_bz,
			cpu_pkg::op_bnz,
			cpu_pkg::op_bcy,
			cpu_pkg::op_bncy,
			cpu_pkg::op_bs,
			cpu_pkg::op_bns,
			cpu_pkg::op_bv,
			cpu_pkg::op_bnv: ctrl.branch = 1'b1;
			cpu_pkg::op_b: ctrl.jump = 1'b1;
			default: ctrl.alu_wr = 1'b0;  // unknown opcode, nothing happens
		endcase

		// condition sits in the low opcode bits, only looked at on a branch
		ctrl.cond = cpu_pkg::cond_e'(opcode[`CPU_COND_W-1:0]);
	end

endmodule

/* logic/cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

	////////////////////
	// opcodes

	typedef enum logic [`CPU_OPC_W-1:0] {
		op_add   = 6'b000000,
		op_comp  = 6'b000001,
		op_and   = 6'b000010,
		op_xor   = 6'b000011,
		op_shll  = 6'b000100,
		op_shrl  = 6'b000101,
		op_shllv = 6'b000110,
		op_shrlv = 6'b000111,
		op_shra  = 6'b001000,
		op_shrav = 6'b001001,
		op_addi  = 6'b010000,
		op_compi = 6'b010001,
		op_lw    = 6'b010010,
		op_sw    = 6'b010011,
		op_bz    = 6'b100000,
		op_bnz   = 6'b100001,
		op_bcy   = 6'b100010,
		op_bncy  = 6'b100011,
		op_bs    = 6'b100100,
		op_bns   = 6'b100101,
		op_bv    = 6'b100110,
		op_bnv   = 6'b100111,
		op_b     = 6'b101000
	} opcode_e;

	typedef enum logic [`CPU_ALU_OP_W-1:0] {
		alu_add, alu_neg, alu_and, alu_xor, alu_shl, alu_shr, alu_sra
	} alu_op_e;

	// same order as the branch opcodes
	typedef enum logic [`CPU_COND_W-1:0] {
		cond_z, cond_nz, cond_cy, cond_ncy, cond_s, cond_ns, cond_v, cond_nv
	} cond_e;

	////////////////////
	// instruction word, two views

	typedef struct packed {
		opcode_e opcode;
		logic [`CPU_REG_AW-1:0] rs;
		logic [`CPU_REG_AW-1:0] rt;
		logic [`CPU_IMM_W-1:0] imm;
	} instr_r_t;

	typedef struct packed {
		opcode_e opcode;
		logic [`CPU_TARGET_W-1:0] target;
	} instr_j_t;

	typedef union packed {
		instr_r_t r;
		instr_j_t j;
	} instr_u;

	typedef struct packed {
		logic z;
		logic c;
		logic s;
		logic v;
	} flags_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm;
		logic alu_wr;  // result to rs, flags load
		logic load;
		logic store;
		logic branch;
		logic jump;
		cond_e cond;
	} ctrl_t;

	// register write retiring at the next edge
	typedef struct packed {
		logic valid;
		logic [`CPU_REG_AW-1:0] dest;
		logic [`CPU_XLEN-1:0] data;
	} wb_t;

endpackage

/* include/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

////////////////////
// datapath sizes

`define CPU_XLEN        32  // data and pc width
`define CPU_REG_AW      5
`define CPU_REG_COUNT   32
`define CPU_DMEM_AW     6   // word address into data memory
`define CPU_DMEM_DEPTH  64

////////////////////
// instruction word layout

// register/immediate view is opcode | rs | rt | imm
`define CPU_OPC_W       6
`define CPU_IMM_W       16

// branch view is opcode | target
`define CPU_TARGET_W    26

// pc bits kept above the target on a taken branch
`define CPU_PC_HI_W     (`CPU_XLEN - `CPU_TARGET_W)

// control field widths
`define CPU_ALU_OP_W    3
`define CPU_COND_W      3   // low opcode bits of a branch

`endif
